/* common/tlb_pkg.sv */
// translation cache shared definitions
`default_nettype none

package tlb_pkg;

    // page number widths
    localparam int unsigned VPN_W = 20;
    localparam int unsigned PPN_W = 20;

    // apb bus widths, only the low address bits are decoded
    localparam int unsigned ADDR_W = 4;
    localparam int unsigned DATA_W = 32;

    // register map
    localparam logic [ADDR_W-1:0] REG_VPN    = 4'h0;
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4;
    localparam logic [ADDR_W-1:0] REG_PPN    = 4'h8;
    localparam logic [ADDR_W-1:0] REG_FILL   = 4'hC;

    // status word layout
    // hit flag on top, hit index in the low bits
    localparam int unsigned STATUS_HIT_BIT = 31;

    // true when n is a nonzero power of two
    function automatic bit is_pow2(int unsigned n);
        return (n != 0) && ((n & (n - 1)) == 0);
    endfunction

endpackage

`default_nettype wire

/* common/tlb_lookup_if.sv */
// lookup and fill channel
`timescale 1ns/1ps
`default_nettype none

interface tlb_lookup_if import tlb_pkg::*; #(
    parameter int unsigned ENTRIES = 8
);

    localparam int unsigned IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    // request side, driven by the control block
    logic             lookup_valid;
    logic [VPN_W-1:0] vpn;
    logic             fill_valid;
    logic [PPN_W-1:0] fill_ppn;

    // result side, combinational from the entry array
    logic             hit;
    logic [IDX_W-1:0] hit_index;
    logic [PPN_W-1:0] hit_ppn;

    modport ctrl (
        output lookup_valid, vpn, fill_valid, fill_ppn,
        input  hit, hit_index, hit_ppn
    );

    modport array (
        input  lookup_valid, vpn, fill_valid, fill_ppn,
        output hit, hit_index, hit_ppn
    );

endinterface

`default_nettype wire

/* tlb/plru_tree.sv */
// tree pseudo-LRU
`timescale 1ns/1ps
`default_nettype none

module plru_tree import tlb_pkg::*; #(
    parameter int unsigned ENTRIES = 8
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic [ENTRIES-1:0] used_i,
    output logic [ENTRIES-1:0] plru_o
);

    localparam int unsigned LOG_E = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam int unsigned NODES = (ENTRIES > 1) ? ENTRIES - 1 : 1;

    // one bit per internal node, heap order
    // node 0 is the root, children of node n sit at 2n+1 and 2n+2
    // a node bit of 1 points to the upper half below it
    logic [NODES-1:0] tree_q;
    logic [NODES-1:0] tree_d;

    // node that leaf sits under at a given level
    function automatic int unsigned node_of(int unsigned leaf, int unsigned lvl);
        return (1 << lvl) - 1 + (leaf >> (LOG_E - lvl));
    endfunction

    // branch taken toward leaf at a given level
    // level 0 looks at the msb of the index
    function automatic logic dir_of(int unsigned leaf, int unsigned lvl);
        return 1'((leaf >> (LOG_E - lvl - 1)) & 1);
    endfunction

    // elaboration check on the entry count
    if (ENTRIES < 2 || !is_pow2(ENTRIES)) begin : gen_entries_check
        $error("plru_tree: ENTRIES must be a power of two of at least 2");
    end

    // on use, every node along the path turns away from the used leaf
    always_comb begin : tree_update
        tree_d = tree_q;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            if (used_i[i]) begin
                for (int unsigned lvl = 0; lvl < LOG_E; lvl++) begin
                    tree_d[node_of(i, lvl)] = ~dir_of(i, lvl);
                end
            end
        end
    end

    // victim is the one leaf whose whole path agrees with the nodes
    always_comb begin : victim_decode
        plru_o = '1;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            for (int unsigned lvl = 0; lvl < LOG_E; lvl++) begin
                if (tree_q[node_of(i, lvl)] != dir_of(i, lvl)) begin
                    plru_o[i] = 1'b0;
                end
            end
        end
    end

    // all nodes low after reset, so entry 0 is the first victim
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

    // at most one leaf named as victim
    plru_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(plru_o));

endmodule

`default_nettype wire

/* tlb/tlb_entry_array.sv */
// translation entry array
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_array import tlb_pkg::*; #(
    parameter int unsigned ENTRIES = 8
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    tlb_lookup_if.array        lookup,
    input  logic [ENTRIES-1:0] victim_i,
    output logic [ENTRIES-1:0] used_o
);

    localparam int unsigned IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    logic [ENTRIES-1:0] valid_q;
    logic [VPN_W-1:0]   tag_q [ENTRIES];
    logic [PPN_W-1:0]   ppn_q [ENTRIES];

    logic [ENTRIES-1:0] match;
    logic [ENTRIES-1:0] free_vec;
    logic [ENTRIES-1:0] free_low;
    logic [ENTRIES-1:0] fill_sel;
    logic [IDX_W-1:0]   hit_idx;
    logic [PPN_W-1:0]   hit_ppn;

    // compare the requested vpn against every valid tag
    always_comb begin : tag_match
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == lookup.vpn);
        end
    end

    // match is at most one-hot, so or-ing the selected fields is enough
    always_comb begin : hit_encode
        hit_idx = '0;
        hit_ppn = '0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            if (match[i]) begin
                hit_idx = hit_idx | IDX_W'(i);
                hit_ppn = hit_ppn | ppn_q[i];
            end
        end
    end

    assign lookup.hit       = |match;
    assign lookup.hit_index = hit_idx;
    assign lookup.hit_ppn   = hit_ppn;

    // lowest free slot, isolate the lowest set bit of the invalid mask
    assign free_vec = ~valid_q;
    assign free_low = free_vec & (~free_vec + ENTRIES'(1));

    // fill target priority
    // existing entry, then lowest free slot, then plru victim
    always_comb begin : fill_target
        if (|match) begin
            fill_sel = match;
        end else if (|free_vec) begin
            fill_sel = free_low;
        end else begin
            fill_sel = victim_i;
        end
    end

    // hits and fills both count as use for the replacement tree
    assign used_o = lookup.lookup_valid ? match :
                    lookup.fill_valid   ? fill_sel : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (lookup.fill_valid) begin
            valid_q <= valid_q | fill_sel;
        end
    end

    // tag and translation storage
    always_ff @(posedge clk_i) begin
        if (lookup.fill_valid) begin
            for (int unsigned i = 0; i < ENTRIES; i++) begin
                if (fill_sel[i]) begin
                    tag_q[i] <= lookup.vpn;
                    ppn_q[i] <= lookup.fill_ppn;
                end
            end
        end
    end

    // fill policy never creates duplicate tags
    match_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(match));

    used_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(used_o));

    // once full, the tree must name exactly one victim
    victim_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (&valid_q) |-> $onehot(victim_i));

endmodule

`default_nettype wire

/* tlb/tlb_ctrl.sv */
// apb control block
`timescale 1ns/1ps
`default_nettype none

module tlb_ctrl import tlb_pkg::*; #(
    parameter int unsigned ENTRIES = 8
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    tlb_lookup_if.ctrl        lookup
);

    localparam int unsigned IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    logic setup, access, addr_ok;
    logic wr_access, rd_access, wr_vpn, wr_fill;
    logic lookup_q, fill_q, pslverr_q;
    logic hit_q;
    logic [IDX_W-1:0]  idx_q;
    logic [VPN_W-1:0]  vpn_q;
    logic [PPN_W-1:0]  ppn_q;
    logic [PPN_W-1:0]  fill_ppn_q;
    logic [DATA_W-1:0] status_w;

    // apb phase decode
    assign setup     = psel_i & ~penable_i;
    assign access    = psel_i & penable_i;
    assign addr_ok   = paddr_i inside {REG_VPN, REG_STATUS, REG_PPN, REG_FILL};
    assign wr_access = access & pwrite_i & addr_ok;
    assign rd_access = access & ~pwrite_i & addr_ok;
    assign wr_vpn    = wr_access && (paddr_i == REG_VPN);
    assign wr_fill   = wr_access && (paddr_i == REG_FILL);

    // no wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = pslverr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_q   <= 1'b0;
            fill_q     <= 1'b0;
            pslverr_q  <= 1'b0;
            vpn_q      <= '0;
            fill_ppn_q <= '0;
        end else begin
            // request pulses follow the write by one cycle
            lookup_q  <= wr_vpn;
            fill_q    <= wr_fill;
            // flagged in setup so the error lines up with the access cycle
            pslverr_q <= setup & ~addr_ok;
            if (wr_vpn) begin
                vpn_q <= pwdata_i[VPN_W-1:0];
            end
            if (wr_fill) begin
                fill_ppn_q <= pwdata_i[PPN_W-1:0];
            end
        end
    end

    // capture the array result at the end of the lookup cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q <= 1'b0;
            idx_q <= '0;
            ppn_q <= '0;
        end else if (lookup_q) begin
            hit_q <= lookup.hit;
            idx_q <= lookup.hit_index;
            ppn_q <= lookup.hit ? lookup.hit_ppn : '0;
        end
    end

    // fill always targets the last looked-up vpn
    assign lookup.lookup_valid = lookup_q;
    assign lookup.vpn          = vpn_q;
    assign lookup.fill_valid   = fill_q;
    assign lookup.fill_ppn     = fill_ppn_q;

    always_comb begin : status_pack
        status_w                 = '0;
        status_w[STATUS_HIT_BIT] = hit_q;
        status_w[IDX_W-1:0]      = idx_q;
    end

    // read mux, zero outside a valid read access
    always_comb begin : read_mux
        prdata_o = '0;
        if (rd_access) begin
            unique case (paddr_i)
                REG_VPN:    prdata_o = DATA_W'(vpn_q);
                REG_STATUS: prdata_o = status_w;
                REG_PPN:    prdata_o = DATA_W'(ppn_q);
                REG_FILL:   prdata_o = DATA_W'(fill_ppn_q);
                default:    prdata_o = '0;
            endcase
        end
    end

    // host must hold psel through the access phase
    penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        penable_i |-> psel_i);

    lookup_fill_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(lookup.lookup_valid && lookup.fill_valid));

endmodule

`default_nettype wire

/* verilog/tlb_top.sv */
// translation cache top level
`timescale 1ns/1ps
`default_nettype none

module tlb_top import tlb_pkg::*; #(
    parameter int unsigned ENTRIES = 8
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o
);

    // used entry toward the tree, victim back to the array
    logic [ENTRIES-1:0] used;
    logic [ENTRIES-1:0] victim;

    tlb_lookup_if #(.ENTRIES(ENTRIES)) lookup_if ();

    tlb_ctrl #(.ENTRIES(ENTRIES)) tlb_ctrl_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .lookup    (lookup_if.ctrl)
    );

    tlb_entry_array #(.ENTRIES(ENTRIES)) tlb_entry_array_inst (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .lookup   (lookup_if.array),
        .victim_i (victim),
        .used_o   (used)
    );

    plru_tree #(.ENTRIES(ENTRIES)) plru_tree_inst (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .used_i (used),
        .plru_o (victim)
    );

endmodule

`default_nettype wire

/* verif/tlb_checker.sv */
// apb response checker
`timescale 1ns/1ps
`default_nettype none

module tlb_checker import tlb_pkg::*; #(
    parameter int unsigned MAX_CYCLES = 2000
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] prdata_i,
    input  logic              pready_i,
    input  logic              pslverr_i,
    output int                errors_o,
    output int                checked_o,
    output logic              timed_out_o
);

    // one entry per transfer, expected pslverr on top of expected prdata
    logic [DATA_W:0] want_q [$];
    int unsigned     cycles = 0;
    int              errors = 0;
    int              checked = 0;
    logic            timed_out = 1'b0;

    assign errors_o    = errors;
    assign checked_o   = checked;
    assign timed_out_o = timed_out;

    // queued by the driver before the transfer starts
    task automatic expect_access(logic [DATA_W:0] want);
        want_q.push_back(want);
    endtask

    always @(posedge clk_i) begin : compare
        logic [DATA_W:0] want;
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run still active after %0d cycles", MAX_CYCLES);
            errors++;
            timed_out = 1'b1;
        end
        // access edge, no wait states so every access ends here
        if (rst_ni && psel_i && penable_i) begin
            if (pready_i !== 1'b1) begin
                $display("FAIL pready_o offset 0x%h expected 0x%h actual 0x%h",
                         paddr_i, 1'b1, pready_i);
                errors++;
            end
            if (want_q.size() == 0) begin
                $display("transfer at offset 0x%h completed with no expected value queued",
                         paddr_i);
                errors++;
            end else begin
                want = want_q.pop_front();
                checked++;
                if (pslverr_i !== want[DATA_W]) begin
                    $display("FAIL pslverr_o offset 0x%h expected 0x%h actual 0x%h",
                             paddr_i, want[DATA_W], pslverr_i);
                    errors++;
                end
                // read data only matters on reads
                if (!pwrite_i && prdata_i !== want[DATA_W-1:0]) begin
                    $display("FAIL prdata_o offset 0x%h expected 0x%h actual 0x%h",
                             paddr_i, want[DATA_W-1:0], prdata_i);
                    errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_tlb.sv */
// translation cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tlb import tlb_pkg::*; ();

    localparam int unsigned ENTRIES = 8;
    localparam int unsigned IDX_W = $clog2(ENTRIES);
    // about 300 transfers of at most 3 cycles, doubled plus slack
    localparam int unsigned XFERS = 300;
    localparam int unsigned XFER_CYCLES = 3;
    localparam int unsigned TIMEOUT_CYCLES = 2 * XFERS * XFER_CYCLES + 200;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    int                errors;
    int                checked;
    logic              timed_out;
    int                seed = 60356;

    // reference model of the entry array, tree and registers
    logic [ENTRIES-1:0] m_valid;
    logic [VPN_W-1:0]   m_tag [ENTRIES];
    logic [PPN_W-1:0]   m_ppn [ENTRIES];
    logic [ENTRIES-2:0] m_tree;
    logic [VPN_W-1:0]   m_vpn_reg;
    logic [DATA_W-1:0]  m_status;
    logic [PPN_W-1:0]   m_ppn_reg;
    logic [PPN_W-1:0]   m_fill_reg;

    tlb_top #(.ENTRIES(ENTRIES)) tlb_top_inst (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    tlb_checker #(.MAX_CYCLES(TIMEOUT_CYCLES)) tlb_checker_inst (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .prdata_i    (prdata),
        .pready_i    (pready),
        .pslverr_i   (pslverr),
        .errors_o    (errors),
        .checked_o   (checked),
        .timed_out_o (timed_out)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // valid entry holding vpn, or -1
    function automatic int find_entry(logic [VPN_W-1:0] vpn);
        for (int i = 0; i < ENTRIES; i++) begin
            if (m_valid[i] && m_tag[i] == vpn) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int lowest_free();
        for (int i = 0; i < ENTRIES; i++) begin
            if (!m_valid[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // follow the node bits down from the root, 1 means upper half
    function automatic int victim_index();
        int node;
        int idx;
        node = 0;
        idx = 0;
        for (int lvl = 0; lvl < IDX_W; lvl++) begin
            idx = idx * 2 + int'(m_tree[node]);
            node = 2 * node + 1 + int'(m_tree[node]);
        end
        return idx;
    endfunction

    function automatic logic [VPN_W-1:0] new_vpn();
        logic [VPN_W-1:0] vpn;
        do begin
            vpn = VPN_W'(rand_word());
        end while (find_entry(vpn) >= 0);
        return vpn;
    endfunction

    // expected pslverr and prdata for an access at addr
    function automatic logic [DATA_W:0] expected_read(logic [ADDR_W-1:0] addr);
        case (addr)
            REG_VPN:    return {1'b0, DATA_W'(m_vpn_reg)};
            REG_STATUS: return {1'b0, m_status};
            REG_PPN:    return {1'b0, DATA_W'(m_ppn_reg)};
            REG_FILL:   return {1'b0, DATA_W'(m_fill_reg)};
            default:    return {1'b1, {DATA_W{1'b0}}};
        endcase
    endfunction

    // nodes on the used leaf's path point away from it
    task automatic touch(int idx);
        int node;
        int dir;
        node = 0;
        for (int lvl = IDX_W - 1; lvl >= 0; lvl--) begin
            dir = (idx >> lvl) & 1;
            m_tree[node] = (dir == 0);
            node = 2 * node + 1 + dir;
        end
    endtask

    // setup and access phases on falling edges
    task automatic apb_transfer(logic write, logic [ADDR_W-1:0] addr,
                                logic [DATA_W-1:0] data);
        tlb_checker_inst.expect_access(expected_read(addr));
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        do begin
            @(posedge clk);
        end while (!pready);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // vpn write, then status and ppn readback
    task automatic lookup_vpn(logic [VPN_W-1:0] vpn);
        int idx;
        apb_transfer(1'b1, REG_VPN, DATA_W'(vpn));
        idx = find_entry(vpn);
        m_vpn_reg = vpn;
        if (idx >= 0) begin
            touch(idx);
            m_status = (DATA_W'(1) << STATUS_HIT_BIT) | DATA_W'(idx);
            m_ppn_reg = m_ppn[idx];
        end else begin
            m_status = '0;
            m_ppn_reg = '0;
        end
        apb_transfer(1'b0, REG_STATUS, '0);
        apb_transfer(1'b0, REG_PPN, '0);
    endtask

    // existing entry first, then lowest free slot, then plru victim
    task automatic fill_vpn(logic [VPN_W-1:0] vpn, logic [PPN_W-1:0] ppn);
        int idx;
        lookup_vpn(vpn);
        apb_transfer(1'b1, REG_FILL, DATA_W'(ppn));
        m_fill_reg = ppn;
        idx = find_entry(vpn);
        if (idx < 0) begin
            idx = lowest_free();
        end
        if (idx < 0) begin
            idx = victim_index();
        end
        m_valid[idx] = 1'b1;
        m_tag[idx] = vpn;
        m_ppn[idx] = ppn;
        touch(idx);
    endtask

    task automatic check_table();
        for (int i = 0; i < ENTRIES; i++) begin
            lookup_vpn(m_tag[i]);
        end
    endtask

    task automatic end_run();
        $display("tb_tlb: %0d errors over %0d checked transfers", errors, checked);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin : test_sequence
        logic [VPN_W-1:0] ev_vpn;
        clk = 1'b0;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        m_valid = '0;
        m_tree = '0;
        m_vpn_reg = '0;
        m_status = '0;
        m_ppn_reg = '0;
        m_fill_reg = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // empty cache misses
        repeat (4) lookup_vpn(new_vpn());
        // fills land at index 0 upward
        for (int i = 0; i < ENTRIES; i++) begin
            fill_vpn(new_vpn(), PPN_W'(rand_word()));
        end
        check_table();
        // full cache, replacement follows the tree
        repeat (2) begin
            repeat (6) lookup_vpn(m_tag[IDX_W'(rand_word())]);
            ev_vpn = m_tag[victim_index()];
            fill_vpn(new_vpn(), PPN_W'(rand_word()));
            lookup_vpn(ev_vpn);
            check_table();
        end
        // refill of a present vpn updates in place
        fill_vpn(m_tag[IDX_W'(rand_word())], PPN_W'(rand_word()));
        check_table();
        // unmapped offsets error out and leave state alone
        apb_transfer(1'b1, 4'h2, rand_word());
        apb_transfer(1'b0, 4'h6, '0);
        apb_transfer(1'b0, REG_STATUS, '0);
        apb_transfer(1'b0, REG_PPN, '0);
        apb_transfer(1'b0, REG_VPN, '0);
        apb_transfer(1'b0, REG_FILL, '0);
        check_table();
        end_run();
    end

    initial begin : timeout_watch
        wait (timed_out);
        end_run();
    end

endmodule

`default_nettype wire

/* files.f */
common/tlb_pkg.sv
common/tlb_lookup_if.sv
tlb/plru_tree.sv
tlb/tlb_entry_array.sv
tlb/tlb_ctrl.sv
verilog/tlb_top.sv
verif/tlb_checker.sv
verif/tb_tlb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_tlb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "No errors" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
